//--- verilog.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_hazard_unit.sv
source/rv_core.sv
dv/tb_mem_model.sv
dv/tb_rv_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_rv_core
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Regression passed
FAIL_MSG  = Regression failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
();

    logic                    clk;
    logic                    RST_n;
    logic                    stall_en;
    logic [CACHE_ADDR_W-1:0] icache_addr;
    logic [CACHE_ADDR_W-1:0] dcache_addr;
    logic [XLEN-1:0]         icache_rdata;
    logic [XLEN-1:0]         dcache_wdata;
    logic [XLEN-1:0]         dcache_rdata;
    logic [XLEN-1:0]         pc;
    logic                    icache_stall;
    logic                    dcache_stall;
    logic                    dcache_ren;
    logic                    dcache_wen;
    logic [XLEN-1:0]         prog[$];
    logic [XLEN-1:0]         exp_addr[$];
    logic [XLEN-1:0]         exp_data[$];
    logic [XLEN-1:0]         got_addr[$];
    logic [XLEN-1:0]         got_data[$];
    int                      tests_run;
    int                      tests_failed;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    rv_core DUT (
        .clk(clk), .RST_n(RST_n), .icache_addr(icache_addr), .icache_stall(icache_stall),
        .icache_rdata(icache_rdata), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
        .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata), .dcache_stall(dcache_stall),
        .dcache_rdata(dcache_rdata), .pc(pc)
    );

    tb_mem_model u_mem (
        .clk(clk), .stall_en(stall_en), .icache_addr(icache_addr),
        .icache_rdata(icache_rdata), .icache_stall(icache_stall), .dcache_ren(dcache_ren),
        .dcache_wen(dcache_wen), .dcache_addr(dcache_addr), .dcache_wdata(dcache_wdata),
        .dcache_rdata(dcache_rdata), .dcache_stall(dcache_stall)
    );

    function automatic logic [XLEN-1:0] byte_swap(input logic [XLEN-1:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // sw rs, addr(x0) plus the word it has to write
    task automatic store_check(input logic [4:0] rs, input logic [11:0] addr,
                               input logic [XLEN-1:0] value);
        prog.push_back(s_type(rs, 5'd0, addr));
        exp_addr.push_back({20'd0, addr});
        exp_data.push_back(value);
    endtask

    task automatic run_program(input string name);
        logic [XLEN-1:0] halt_pc;
        logic            wen_seen;
        logic [XLEN-1:0] addr_seen;
        logic [XLEN-1:0] data_seen;
        logic [XLEN-1:0] pc_seen;
        int              cycles;
        int              hits;
        int              errs;
        halt_pc = prog.size() * 4;
        prog.push_back(j_type(5'd0, 21'd0));  // Self-jump
        @(negedge clk);
        RST_n = 1'b0;
        u_mem.clear(byte_swap(NOP_INST));
        foreach (prog[i]) begin
            u_mem.load_inst(i, byte_swap(prog[i]));
        end
        got_addr.delete();
        got_data.delete();
        repeat (4) @(negedge clk);
        RST_n  = 1'b1;
        cycles = 0;
        hits   = 0;
        errs   = 0;
        // Third unstalled fetch of the self-jump means older stores have drained
        while (hits < 3 && cycles < 2000) begin
            wen_seen  = dcache_wen;  // Mid-cycle view of the memory stage
            addr_seen = {dcache_addr, 2'b00};
            data_seen = byte_swap(dcache_wdata);  // Data port words arrive byte-swapped
            pc_seen   = pc;
            @(posedge clk);
            if (!icache_stall && !dcache_stall) begin  // This edge moved the pipeline
                if (wen_seen) begin
                    got_addr.push_back(addr_seen);
                    got_data.push_back(data_seen);
                end
                if (pc_seen == halt_pc) begin
                    hits++;
                end
            end
            cycles++;
            @(negedge clk);
        end
        assert (hits == 3) else begin
            $display("%s: core never reached its halt loop within 2000 cycles", name);
            errs++;
        end
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("%s: %0d stores seen but %0d expected", name, got_addr.size(),
                     exp_addr.size());
            errs++;
        end
        foreach (exp_addr[i]) begin
            if (i < got_addr.size()) begin
                assert (got_addr[i] == exp_addr[i]) else begin
                    $display("FAILED %0t dcache_addr store %0d got %h expected %h", $time, i,
                             got_addr[i], exp_addr[i]);
                    errs++;
                end
                assert (got_data[i] == exp_data[i]) else begin
                    $display("FAILED %0t dcache_wdata store %0d got %h expected %h", $time, i,
                             got_data[i], exp_data[i]);
                    errs++;
                end
            end
        end
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d stores, %0d errors", name, got_addr.size(), errs);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic alu_ops(input string name);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] k;
        a = 32'd1459;
        b = -32'd622;
        k = -32'd93;
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, a[11:0]));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd0, b[11:0]));
        prog.push_back(r_type(3'b000, 7'h00, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd0, a + b);
        prog.push_back(r_type(3'b000, 7'h20, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd4, a - b);
        prog.push_back(r_type(3'b111, 7'h00, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd8, a & b);
        prog.push_back(r_type(3'b110, 7'h00, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd12, a | b);
        prog.push_back(r_type(3'b100, 7'h00, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd16, a ^ b);
        prog.push_back(r_type(3'b010, 7'h00, 5'd3, 5'd1, 5'd2));
        store_check(5'd3, 12'd20, {31'd0, $signed(a) < $signed(b)});
        prog.push_back(r_type(3'b010, 7'h00, 5'd3, 5'd2, 5'd1));
        store_check(5'd3, 12'd24, {31'd0, $signed(b) < $signed(a)});
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd1, k[11:0]));
        store_check(5'd3, 12'd28, a + k);
        prog.push_back(i_type(OP_IMM, 3'b111, 5'd3, 5'd1, k[11:0]));
        store_check(5'd3, 12'd32, a & k);
        prog.push_back(i_type(OP_IMM, 3'b110, 5'd3, 5'd1, k[11:0]));
        store_check(5'd3, 12'd36, a | k);
        prog.push_back(i_type(OP_IMM, 3'b100, 5'd3, 5'd1, k[11:0]));
        store_check(5'd3, 12'd40, a ^ k);
        prog.push_back(i_type(OP_IMM, 3'b010, 5'd3, 5'd2, k[11:0]));
        store_check(5'd3, 12'd44, {31'd0, $signed(b) < $signed(k)});
        run_program(name);
    endtask

    task automatic forwarding(input string name);
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        logic [XLEN-1:0] v3;
        v1 = 32'd100 + 32'd7;
        v2 = v1 + 32'd1;
        v3 = v2 + v1;
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd100));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd1, 12'd7));  // Distance 1
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd5));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd4, 5'd2, 12'd1));  // Distance 2
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd5, 5'd0, 12'd9));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd6, 5'd0, 12'd11));
        prog.push_back(r_type(3'b000, 7'h00, 5'd7, 5'd4, 5'd2));    // Distance 3
        prog.push_back(r_type(3'b000, 7'h00, 5'd8, 5'd7, 5'd7));
        store_check(5'd2, 12'd0, v1);
        store_check(5'd4, 12'd4, v2);
        store_check(5'd7, 12'd8, v3);
        store_check(5'd8, 12'd12, v3 + v3);
        run_program(name);
    endtask

    task automatic load_use(input string name);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] k;
        a = 32'd1234;
        k = -32'd5;
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, a[11:0]));
        store_check(5'd1, 12'd16, a);
        prog.push_back(i_type(OP_LOAD, 3'b010, 5'd2, 5'd0, 12'd16));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd2, k[11:0]));  // Uses the load at once
        store_check(5'd3, 12'd20, a + k);
        prog.push_back(i_type(OP_LOAD, 3'b010, 5'd4, 5'd0, 12'd16));
        prog.push_back(r_type(3'b000, 7'h00, 5'd5, 5'd4, 5'd1));
        store_check(5'd5, 12'd24, a + a);
        prog.push_back(i_type(OP_LOAD, 3'b010, 5'd6, 5'd0, 12'd20));
        store_check(5'd6, 12'd28, a + k);  // Load feeds store data
        run_program(name);
    endtask

    task automatic control_flow(input string name);
        logic [XLEN-1:0] r1;
        logic [XLEN-1:0] r2;
        logic [XLEN-1:0] r3;
        logic [XLEN-1:0] r4;
        logic [XLEN-1:0] link;
        r1 = 32'd3;
        r2 = 32'd3;
        r3 = 32'd7;
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd3));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd2, 5'd0, 12'd3));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd7));
        prog.push_back(b_type(3'b000, 5'd1, 5'd2, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd3, 5'd0, 12'd99));
        store_check(5'd3, 12'd0, (r1 == r2) ? r3 : 32'd99);
        prog.push_back(b_type(3'b001, 5'd1, 5'd2, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd4, 5'd0, 12'd21));
        r4 = (r1 != r2) ? 32'd0 : 32'd21;
        store_check(5'd4, 12'd4, r4);
        prog.push_back(b_type(3'b000, 5'd1, 5'd3, 13'd8));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd4, 5'd4, 12'd1));
        r4 = (r1 == r3) ? r4 : r4 + 32'd1;
        store_check(5'd4, 12'd8, r4);
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd6, 5'd0, 12'd8));
        prog.push_back(b_type(3'b001, 5'd6, 5'd3, 13'd8));  // Compare value still in execute
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd4, 5'd0, 12'd0));
        r4 = (32'd8 != r3) ? r4 : 32'd0;
        store_check(5'd4, 12'd12, r4);
        link = prog.size() * 4 + 4;
        prog.push_back(j_type(5'd5, 21'd8));
        prog.push_back(i_type(OP_IMM, 3'b000, 5'd5, 5'd0, 12'd55));
        store_check(5'd5, 12'd16, link);
        run_program(name);
    endtask

    initial begin
        RST_n        = 1'b0;
        stall_en     = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        alu_ops("alu_ops");
        forwarding("forwarding");
        load_use("load_use");
        control_flow("control_flow");
        @(posedge clk);
        stall_en = 1'b1;  // Random cache stalls from here on
        alu_ops("alu_ops_stalls");
        load_use("load_use_stalls");
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     stall_en,
    input  wire  [CACHE_ADDR_W-1:0] icache_addr,
    output logic [XLEN-1:0]         icache_rdata,
    output logic                    icache_stall,
    input  wire                     dcache_ren,
    input  wire                     dcache_wen,
    input  wire  [CACHE_ADDR_W-1:0] dcache_addr,
    input  wire  [XLEN-1:0]         dcache_wdata,
    output logic [XLEN-1:0]         dcache_rdata,
    output logic                    dcache_stall
);

    integer          seed;
    logic [31:0]     istall_roll;
    logic [31:0]     dstall_roll;
    logic [XLEN-1:0] rom  [64];  // Words kept in cache byte order
    logic [XLEN-1:0] dmem [64];

    initial begin
        seed         = 32'h94f5cc03;
        icache_stall = 1'b0;
        dcache_stall = 1'b0;
    end

    assign icache_rdata = rom[icache_addr[5:0]];
    assign dcache_rdata = dcache_ren ? dmem[dcache_addr[5:0]] : '0;

    // Both rolls are drawn every cycle so the sequence stays fixed
    always @(negedge clk) begin
        istall_roll  = $random(seed);
        dstall_roll  = $random(seed);
        icache_stall = stall_en && (istall_roll[1:0] == 2'b00);
        dcache_stall = stall_en && (dstall_roll[1:0] == 2'b00);
    end

    always @(posedge clk) begin
        if (dcache_wen && !icache_stall && !dcache_stall) begin
            dmem[dcache_addr[5:0]] = dcache_wdata;  // Store retires only when unstalled
        end
    end

    task automatic clear(input logic [XLEN-1:0] fill_inst);
        for (int i = 0; i < 64; i++) begin
            rom[i]  = fill_inst;
            dmem[i] = 32'hDA7A_0000 | i;  // Marks each word with its own index
        end
    endtask

    task automatic load_inst(input int idx, input logic [XLEN-1:0] word);
        rom[idx] = word;
    endtask

endmodule

`default_nettype wire

//--- source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     RST_n,
    output logic [CACHE_ADDR_W-1:0] icache_addr,
    input  wire                     icache_stall,
    input  wire  [XLEN-1:0]         icache_rdata,
    output logic                    dcache_ren,
    output logic                    dcache_wen,
    output logic [CACHE_ADDR_W-1:0] dcache_addr,
    output logic [XLEN-1:0]         dcache_wdata,
    input  wire                     dcache_stall,
    input  wire  [XLEN-1:0]         dcache_rdata,
    output logic [XLEN-1:0]         pc
);

    logic                  stall;
    logic [XLEN-1:0]       fetch_word;
    logic [XLEN-1:0]       if_inst;
    logic [XLEN-1:0]       if_pc;
    logic                  dec_reg_write, dec_alu_src, dec_mem_to_reg, dec_mem_write;
    logic                  dec_is_load, dec_branch_eq, dec_branch_ne, dec_jal;
    logic [XLEN-1:0]       dec_imm;
    alu_op_e               dec_alu_op;
    logic [REG_ADDR_W-1:0] id_rs1, id_rs2;
    logic [XLEN-1:0]       rf_rs1, rf_rs2, cmp_a, cmp_b, br_target;
    logic                  br_taken, redirect, load_use_bubble;
    fwd_sel_e              fwd_a, fwd_b, br_sel_a, br_sel_b;
    logic                  ex_reg_write, ex_mem_write, ex_mem_to_reg, ex_is_load, ex_alu_src;
    alu_op_e               ex_alu_op;
    logic [REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [XLEN-1:0]       ex_rs1_val, ex_rs2_val, ex_imm;
    logic [XLEN-1:0]       ex_op_a, ex_op_b, ex_op_b_reg, alu_result;
    logic                  mem_reg_write, mem_mem_write, mem_mem_to_reg;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_alu, mem_wdata, load_word, mem_fwd_val;
    logic                  wb_reg_write;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel, input logic [XLEN-1:0] base,
                                             input logic [XLEN-1:0] ex_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_fwd_val;
            FWD_WB:  return wb_data;
            default: return base;
        endcase
    endfunction

    assign stall = icache_stall | dcache_stall;

    assign icache_addr = pc[XLEN-1:XLEN-CACHE_ADDR_W];
    assign fetch_word  = {<<8{icache_rdata}};  // Caches store words byte-swapped

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            pc      <= '0;
            if_inst <= NOP_INST;
        end else if (!stall && !load_use_bubble) begin
            pc      <= redirect ? br_target : pc + PC_STEP;
            if_inst <= redirect ? NOP_INST : fetch_word;  // Squash the fall-through word
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !load_use_bubble) begin
            if_pc <= pc;
        end
    end

    rv_decoder u_decoder (
        .inst(if_inst), .reg_write(dec_reg_write), .alu_src(dec_alu_src),
        .mem_to_reg(dec_mem_to_reg), .mem_write(dec_mem_write), .is_load(dec_is_load),
        .branch_eq(dec_branch_eq), .branch_ne(dec_branch_ne), .jal(dec_jal),
        .imm(dec_imm), .alu_op(dec_alu_op)
    );

    // jal holds immediate bits in the source fields
    assign id_rs1 = dec_jal ? '0 : if_inst[19:15];
    assign id_rs2 = dec_jal ? '0 : if_inst[24:20];

    rv_regfile u_regfile (
        .clk(clk), .RST_n(RST_n), .rs1_addr(id_rs1), .rs2_addr(id_rs2), .rd_addr(wb_rd),
        .wr_en(wb_reg_write && !stall), .wr_data(wb_data), .rs1_data(rf_rs1), .rs2_data(rf_rs2)
    );

    always_comb begin
        cmp_a = pick(br_sel_a, rf_rs1, alu_result);
        cmp_b = pick(br_sel_b, rf_rs2, alu_result);
    end

    assign br_target = if_pc + dec_imm;
    assign br_taken  = (dec_branch_eq && cmp_a == cmp_b) || (dec_branch_ne && cmp_a != cmp_b);
    assign redirect  = br_taken || dec_jal;

    always_ff @(posedge clk) begin
        if (!RST_n || (!stall && load_use_bubble)) begin
            ex_reg_write  <= 1'b0;  // Reset and load-use bubble look alike
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_is_load    <= 1'b0;
            ex_alu_src    <= 1'b0;
            ex_alu_op     <= ALU_NONE;
            ex_rs1        <= '0;
            ex_rs2        <= '0;
            ex_rd         <= '0;
        end else if (!stall) begin
            ex_reg_write  <= dec_reg_write;
            ex_mem_write  <= dec_mem_write;
            ex_mem_to_reg <= dec_mem_to_reg;
            ex_is_load    <= dec_is_load;
            ex_alu_src    <= dec_alu_src;
            ex_alu_op     <= dec_alu_op;
            ex_rs1        <= id_rs1;
            ex_rs2        <= id_rs2;
            ex_rd         <= if_inst[11:7];
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_rs1_val <= (br_sel_a == FWD_WB) ? wb_data : rf_rs1;  // WB write not yet in RF
            ex_rs2_val <= (br_sel_b == FWD_WB) ? wb_data : rf_rs2;
            ex_imm     <= dec_jal ? if_pc + PC_STEP : dec_imm;  // Link address for jal
        end
    end

    always_comb begin
        ex_op_a     = pick(fwd_a, ex_rs1_val, ex_rs1_val);
        ex_op_b_reg = pick(fwd_b, ex_rs2_val, ex_rs2_val);
    end

    assign ex_op_b = ex_alu_src ? ex_imm : ex_op_b_reg;

    rv_alu u_alu (.op(ex_alu_op), .a(ex_op_a), .b(ex_op_b), .result(alu_result));

    rv_hazard_unit u_hazard (
        .clk(clk), .RST_n(RST_n), .id_rs1(id_rs1), .id_rs2(id_rs2),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .ex_reg_write(ex_reg_write), .mem_reg_write(mem_reg_write),
        .wb_reg_write(wb_reg_write), .ex_is_load(ex_is_load),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .br_sel_a(br_sel_a), .br_sel_b(br_sel_b),
        .load_use_bubble(load_use_bubble)
    );

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            mem_reg_write  <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            mem_rd         <= '0;
        end else if (!stall) begin
            mem_reg_write  <= ex_reg_write;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
            mem_rd         <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mem_alu   <= alu_result;
            mem_wdata <= ex_op_b_reg;  // Store data after forwarding
        end
    end

    assign load_word    = {<<8{dcache_rdata}};
    assign mem_fwd_val  = mem_mem_to_reg ? load_word : mem_alu;
    assign dcache_ren   = mem_mem_to_reg;
    assign dcache_wen   = mem_mem_write;
    assign dcache_addr  = mem_alu[XLEN-1:XLEN-CACHE_ADDR_W];
    assign dcache_wdata = {<<8{mem_wdata}};

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
        end else if (!stall) begin
            wb_reg_write <= mem_reg_write;
            wb_rd        <= mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wb_data <= mem_fwd_val;
        end
    end

    // Decoder never marks one instruction as both load and store
    a_dcache_exclusive: assert property (@(posedge clk) disable iff (!RST_n)
        !(dcache_ren && dcache_wen))
        else $error("rv_core: dcache read and write in the same cycle");

endmodule

`default_nettype wire

//--- source/rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit
    import rv_pkg::*;
(
    input  wire                  clk,
    input  wire                  RST_n,
    input  wire [REG_ADDR_W-1:0] id_rs1,
    input  wire [REG_ADDR_W-1:0] id_rs2,
    input  wire [REG_ADDR_W-1:0] ex_rs1,
    input  wire [REG_ADDR_W-1:0] ex_rs2,
    input  wire [REG_ADDR_W-1:0] ex_rd,
    input  wire [REG_ADDR_W-1:0] mem_rd,
    input  wire [REG_ADDR_W-1:0] wb_rd,
    input  wire                  ex_reg_write,
    input  wire                  mem_reg_write,
    input  wire                  wb_reg_write,
    input  wire                  ex_is_load,
    output fwd_sel_e             fwd_a,
    output fwd_sel_e             fwd_b,
    output fwd_sel_e             br_sel_a,
    output fwd_sel_e             br_sel_b,
    output logic                 load_use_bubble
);

    function automatic logic hit(input logic [REG_ADDR_W-1:0] rd, input logic we,
                                 input logic [REG_ADDR_W-1:0] rs);
        return we && (rd != '0) && (rd == rs);  // x0 never forwards
    endfunction

    // Execute operands, youngest producer first
    function automatic fwd_sel_e ex_sel(input logic [REG_ADDR_W-1:0] rs);
        if (hit(mem_rd, mem_reg_write, rs)) return FWD_MEM;
        if (hit(wb_rd, wb_reg_write, rs)) return FWD_WB;
        return FWD_NONE;
    endfunction

    // Decode comparator also sees the result still in execute
    function automatic fwd_sel_e id_sel(input logic [REG_ADDR_W-1:0] rs);
        if (hit(ex_rd, ex_reg_write, rs)) return FWD_EX;
        if (hit(mem_rd, mem_reg_write, rs)) return FWD_MEM;
        if (hit(wb_rd, wb_reg_write, rs)) return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a    = ex_sel(ex_rs1);
        fwd_b    = ex_sel(ex_rs2);
        br_sel_a = id_sel(id_rs1);
        br_sel_b = id_sel(id_rs2);
    end

    assign load_use_bubble = hit(ex_rd, ex_is_load, id_rs1) || hit(ex_rd, ex_is_load, id_rs2);

    // A second bubble cycle is only legal when a cache stall froze the pipeline
    a_single_bubble: assert property (@(posedge clk) disable iff (!RST_n)
        load_use_bubble && $past(load_use_bubble) |->
            $stable(ex_rd) && $stable(ex_is_load) && $stable(id_rs1) && $stable(id_rs2))
        else $error("rv_hazard_unit: load-use bubble repeated without a stall");

endmodule

`default_nettype wire

//--- source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu
    import rv_pkg::*;
(
    input  var alu_op_e         op,
    input  wire  [XLEN-1:0]     a,
    input  wire  [XLEN-1:0]     b,
    output logic [XLEN-1:0]     result
);

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_XOR:    result = a ^ b;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_PASS_B: result = b;
            default:    result = '0;  // Bubbles compute nothing
        endcase
    end

    // An operation code outside the enum means a corrupted ID/EX register
    always_comb begin
        if (!$isunknown(op)) begin
            assert (op inside {ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLT,
                               ALU_PASS_B, ALU_NONE})
                else $error("rv_alu: illegal op %0d", op);
        end
    end

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
    import rv_pkg::*;
(
    input  wire                   clk,
    input  wire                   RST_n,
    input  wire  [REG_ADDR_W-1:0] rs1_addr,
    input  wire  [REG_ADDR_W-1:0] rs2_addr,
    input  wire  [REG_ADDR_W-1:0] rd_addr,
    input  wire                   wr_en,
    input  wire  [XLEN-1:0]       wr_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!RST_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd_addr != '0) begin
            regs[rd_addr] <= wr_data;  // x0 is never written
        end
    end

    // Reads see the old value in the write cycle
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

//--- source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder
    import rv_pkg::*;
(
    input  wire  [XLEN-1:0] inst,
    output logic            reg_write,
    output logic            alu_src,
    output logic            mem_to_reg,
    output logic            mem_write,
    output logic            is_load,
    output logic            branch_eq,
    output logic            branch_ne,
    output logic            jal,
    output logic [XLEN-1:0] imm,
    output alu_op_e         alu_op
);

    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign funct3 = inst[14:12];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        is_load    = 1'b0;
        branch_eq  = 1'b0;
        branch_ne  = 1'b0;
        jal        = 1'b0;
        imm        = '0;
        alu_op     = ALU_NONE;
        case (opcode_e'(inst[6:0]))
            OP_R, OP_IMM: begin
                reg_write = 1'b1;
                alu_src   = (inst[6:0] == OP_IMM);
                imm       = imm_i;
                case (funct3)
                    3'b000:  alu_op = (inst[5] && inst[30]) ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: reg_write = 1'b0;  // Shifts and sltu become a NOP
                endcase
            end
            OP_LOAD: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                is_load    = 1'b1;
                imm        = imm_i;
                alu_op     = ALU_ADD;  // Address = rs1 + offset
            end
            OP_STORE: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                imm       = imm_s;
                alu_op    = ALU_ADD;
            end
            OP_BRANCH: begin
                branch_eq = (funct3 == 3'b000);
                branch_ne = (funct3 == 3'b001);
                imm       = imm_b;
            end
            OP_JAL: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm       = imm_j;
                alu_op    = ALU_PASS_B;
            end
            default: ;  // Unknown opcode decodes as NOP
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int NUM_REGS     = 32;
    localparam int CACHE_ADDR_W = 30;  // Word address at both caches
    localparam int PC_STEP      = 4;

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_XOR    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_AND    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_PASS_B = 4'd6,  // Link value for jal
        ALU_NONE   = 4'd7   // Reset and bubble value
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // Register file value
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2,
        FWD_EX   = 2'd3   // Decode comparator only
    } fwd_sel_e;

endpackage

`default_nettype wire
